//--- design/gmii_rx_monitor.sv
`default_nettype none

// receive statistics as the mac status block would read them
// everything registered, counts lag the gmii signals by one rx clock
module gmii_rx_monitor import rgmii_pkg::*; (
    input  wire       gmii_rx_clk_i,
    input  wire       rst_i,
    input  wire       gmii_rx_dv_i,
    input  wire       gmii_rx_er_i,
    output stat_cnt_t frame_cnt_o,     // frames ended
    output stat_cnt_t byte_cnt_o,      // bytes with dv
    output stat_cnt_t err_cnt_o,       // bytes with dv and er
    output stat_cnt_t bad_frame_cnt_o  // frames holding at least one er byte
);

    logic dv_q;       // dv one clock back, for the end of frame
    logic err_seen;   // sticky over the current frame
    logic frame_end;  // dv just dropped
    logic err_byte;   // errored data byte, not carrier extension

    assign frame_end = dv_q & ~gmii_rx_dv_i;
    assign err_byte  = gmii_rx_dv_i & gmii_rx_er_i; // er alone is ignored

    always_ff @(posedge gmii_rx_clk_i)
    begin
        if (rst_i)
        begin
            dv_q            <= 1'b0;
            err_seen        <= 1'b0;
            frame_cnt_o     <= '0;
            byte_cnt_o      <= '0;
            err_cnt_o       <= '0;
            bad_frame_cnt_o <= '0;
        end
        else
        begin
            dv_q <= gmii_rx_dv_i;

            if (gmii_rx_dv_i)
                byte_cnt_o <= byte_cnt_o + stat_cnt_t'(1);

            if (err_byte)
            begin
                err_cnt_o <= err_cnt_o + stat_cnt_t'(1);
                err_seen  <= 1'b1; // held until the frame closes
            end

            // dv is low here, so no new error can collide with the clear
            if (frame_end)
            begin
                frame_cnt_o <= frame_cnt_o + stat_cnt_t'(1);
                err_seen    <= 1'b0;
                if (err_seen)
                    bad_frame_cnt_o <= bad_frame_cnt_o + stat_cnt_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/gmii_to_rgmii.sv
`default_nettype none

`include "rgmii_consts.svh"

// gmii <-> rgmii conversion, behavioral ddr cells in place of pad primitives
module gmii_to_rgmii import rgmii_pkg::*; #(
    parameter bit in_phase_tx_clk = 1'b0 // 0: forward the 90 degree clock
) (
    input  wire          gmii_tx_clk_i,   // from mac
    input  wire          gmii_tx_clk90_i, // from mac, shifted quarter period
    input  wire          rgmii_rx_clk_i,  // from phy
    input  wire          rst_i,
    input  wire octet_t  gmii_txd_i,
    input  wire          gmii_tx_en_i,
    input  wire          gmii_tx_er_i,
    output wire nibble_t rgmii_txd_o,     // to phy
    output wire          rgmii_tx_ctl_o,
    output wire          rgmii_tx_clk_o,
    input  wire nibble_t rgmii_rxd_i,     // from phy
    input  wire          rgmii_rx_ctl_i,
    output wire          gmii_rx_clk_o,   // to mac
    output octet_t       gmii_rxd_o,
    output logic         gmii_rx_dv_o,
    output logic         gmii_rx_er_o
);

    logic    tx_fwd_clk;  // clock that runs the forwarding cell
    logic    tx_ctl_fall; // second phase of tx_ctl
    nibble_t rxd_rise;    // low nibble back from the pins
    nibble_t rxd_fall;    // high nibble
    logic    rx_ctl_rise;
    logic    rx_ctl_fall;

    // some phys want an in-phase clock, others rely on the 90 degree shift
    assign tx_fwd_clk = in_phase_tx_clk ? gmii_tx_clk_i : gmii_tx_clk90_i;

    // er is folded into the low phase of the control line
    assign tx_ctl_fall = gmii_tx_en_i ^ gmii_tx_er_i;

    rgmii_oddr #(.lane_t(nibble_t)) u_txd_oddr (
        .clk_i    (gmii_tx_clk_i),
        .rst_i    (rst_i),
        .d_rise_i (gmii_txd_i[`NIBBLE_W-1:0]),        // low nibble first
        .d_fall_i (gmii_txd_i[`OCTET_W-1:`NIBBLE_W]),
        .q_o      (rgmii_txd_o)
    );

    rgmii_oddr #(.lane_t(logic)) u_tx_ctl_oddr (
        .clk_i    (gmii_tx_clk_i),
        .rst_i    (rst_i),
        .d_rise_i (gmii_tx_en_i),
        .d_fall_i (tx_ctl_fall),
        .q_o      (rgmii_tx_ctl_o)
    );

    // forwarded clock, a ddr cell fed with fixed 1/0 keeps it matched to data
    rgmii_oddr #(.lane_t(logic)) u_tx_clk_oddr (
        .clk_i    (tx_fwd_clk),
        .rst_i    (rst_i),
        .d_rise_i (1'b1),
        .d_fall_i (1'b0),
        .q_o      (rgmii_tx_clk_o)
    );

    rgmii_iddr #(.lane_t(nibble_t)) u_rxd_iddr (
        .clk_i    (rgmii_rx_clk_i),
        .rst_i    (rst_i),
        .d_i      (rgmii_rxd_i),
        .q_rise_o (rxd_rise),
        .q_fall_o (rxd_fall)
    );

    rgmii_iddr #(.lane_t(logic)) u_rx_ctl_iddr (
        .clk_i    (rgmii_rx_clk_i),
        .rst_i    (rst_i),
        .d_i      (rgmii_rx_ctl_i),
        .q_rise_o (rx_ctl_rise),
        .q_fall_o (rx_ctl_fall)
    );

    assign gmii_rx_clk_o = rgmii_rx_clk_i;           // no regional buffer in sim
    assign gmii_rxd_o    = {rxd_fall, rxd_rise};     // high nibble came second
    assign gmii_rx_dv_o  = rx_ctl_rise;
    assign gmii_rx_er_o  = rx_ctl_rise ^ rx_ctl_fall; // undo the tx xor

endmodule

`default_nettype wire

//--- design/rgmii_consts.svh
`ifndef RGMII_CONSTS_SVH
`define RGMII_CONSTS_SVH

// rgmii lane group, one nibble per clock phase
`define NIBBLE_W 4

// gmii byte, two nibbles per clock
`define OCTET_W 8

// statistics counters, wrap silently at the top
`define CNT_W 16

`endif

//--- design/rgmii_iddr.sv
`default_nettype none

// same-edge-pipelined ddr input cell
// rise sample and fall sample leave together after the next rising edge
module rgmii_iddr #(
    parameter type lane_t = logic
) (
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire lane_t d_i,
    output lane_t      q_rise_o, // sample taken at the rising edge
    output lane_t      q_fall_o  // sample taken at the following falling edge
);

    lane_t rise_s; // first capture stage, rising edge
    lane_t fall_s; // first capture stage, falling edge

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rise_s   <= '0;
            q_rise_o <= '0;
            q_fall_o <= '0;
        end
        else
        begin
            rise_s   <= d_i;
            q_rise_o <= rise_s; // realign the pair on one edge
            q_fall_o <= fall_s;
        end
    end

    // falling-edge capture, reset sampled on this edge as well
    always_ff @(negedge clk_i)
    begin
        if (rst_i)
            fall_s <= '0;
        else
            fall_s <= d_i;
    end

endmodule

`default_nettype wire

//--- design/rgmii_oddr.sv
`default_nettype none

// same-edge ddr output cell
// both phases captured on the rising edge, clock level picks the phase
module rgmii_oddr #(
    parameter type lane_t = logic
) (
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire lane_t d_rise_i, // driven during high phase
    input  wire lane_t d_fall_i, // driven during low phase
    output lane_t      q_o
);

    lane_t rise_q; // high phase value
    lane_t fall_q; // low phase value

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rise_q <= '0;  // pins idle low out of reset
            fall_q <= '0;
        end
        else
        begin
            rise_q <= d_rise_i;
            fall_q <= d_fall_i;
        end
    end

    // behavioral stand-in for the oddr output mux
    assign q_o = clk_i ? rise_q : fall_q;

endmodule

`default_nettype wire

//--- design/rgmii_pkg.sv
`default_nettype none

`include "rgmii_consts.svh"

package rgmii_pkg;

    // one ddr lane group on the rgmii pins
    typedef logic [`NIBBLE_W-1:0] nibble_t;

    // gmii data byte, low nibble goes out first
    typedef logic [`OCTET_W-1:0] octet_t;

    // one status counter as the mac reads it
    typedef logic [`CNT_W-1:0] stat_cnt_t;

endpackage

`default_nettype wire

//--- design/rgmii_port.sv
`default_nettype none

// rgmii port of the mac: converter plus receive statistics
module rgmii_port import rgmii_pkg::*; #(
    parameter bit in_phase_tx_clk = 1'b0
) (
    input  wire            gmii_tx_clk_i,
    input  wire            gmii_tx_clk90_i,
    input  wire            rgmii_rx_clk_i,
    input  wire            rst_i,
    input  wire octet_t    gmii_txd_i,
    input  wire            gmii_tx_en_i,
    input  wire            gmii_tx_er_i,
    output wire nibble_t   rgmii_txd_o,
    output wire            rgmii_tx_ctl_o,
    output wire            rgmii_tx_clk_o,
    input  wire nibble_t   rgmii_rxd_i,
    input  wire            rgmii_rx_ctl_i,
    output wire            gmii_rx_clk_o,
    output wire octet_t    gmii_rxd_o,
    output wire            gmii_rx_dv_o,
    output wire            gmii_rx_er_o,
    output wire stat_cnt_t frame_cnt_o,
    output wire stat_cnt_t byte_cnt_o,
    output wire stat_cnt_t err_cnt_o,
    output wire stat_cnt_t bad_frame_cnt_o
);

    gmii_to_rgmii #(
        .in_phase_tx_clk (in_phase_tx_clk)
    ) uut_conv (
        .gmii_tx_clk_i   (gmii_tx_clk_i),
        .gmii_tx_clk90_i (gmii_tx_clk90_i),
        .rgmii_rx_clk_i  (rgmii_rx_clk_i),
        .rst_i           (rst_i),
        .gmii_txd_i      (gmii_txd_i),
        .gmii_tx_en_i    (gmii_tx_en_i),
        .gmii_tx_er_i    (gmii_tx_er_i),
        .rgmii_txd_o     (rgmii_txd_o),
        .rgmii_tx_ctl_o  (rgmii_tx_ctl_o),
        .rgmii_tx_clk_o  (rgmii_tx_clk_o),
        .rgmii_rxd_i     (rgmii_rxd_i),
        .rgmii_rx_ctl_i  (rgmii_rx_ctl_i),
        .gmii_rx_clk_o   (gmii_rx_clk_o),
        .gmii_rxd_o      (gmii_rxd_o),
        .gmii_rx_dv_o    (gmii_rx_dv_o),
        .gmii_rx_er_o    (gmii_rx_er_o)
    );

    // statistics live in the recovered rx clock domain
    gmii_rx_monitor u_rx_mon (
        .gmii_rx_clk_i   (gmii_rx_clk_o),
        .rst_i           (rst_i),
        .gmii_rx_dv_i    (gmii_rx_dv_o),
        .gmii_rx_er_i    (gmii_rx_er_o),
        .frame_cnt_o     (frame_cnt_o),
        .byte_cnt_o      (byte_cnt_o),
        .err_cnt_o       (err_cnt_o),
        .bad_frame_cnt_o (bad_frame_cnt_o)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the rgmii loopback testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module tb_rgmii_port -o tb_rgmii_port

./obj_dir/tb_rgmii_port > sim.log
cat sim.log

if grep -q "Verification failed" sim.log
then
    echo "run_sim: simulation reported failures"
    exit 1
fi
echo "run_sim: simulation clean"

//--- sources.f
+incdir+design
design/rgmii_pkg.sv
design/rgmii_oddr.sv
design/rgmii_iddr.sv
design/gmii_to_rgmii.sv
design/gmii_rx_monitor.sv
design/rgmii_port.sv
tb/tb_rgmii_port.sv

//--- tb/tb_rgmii_port.sv
`default_nettype none

// loopback testbench, rgmii tx pins wired straight back into the rx pins
module tb_rgmii_port import rgmii_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_FRAMES   = 8;
    localparam int GAP_CYCLES   = 4;  // symbols between frames
    localparam int SETUP_CYCLES = 16; // reset plus drain allowance

    typedef struct packed {
        logic   er;   // rx_er expected with this byte
        octet_t data;
    } exp_byte_t;

    logic      gmii_tx_clk_i;
    logic      gmii_tx_clk90_i;
    logic      rst_i;
    octet_t    gmii_txd_i;
    logic      gmii_tx_en_i;
    logic      gmii_tx_er_i;
    nibble_t   rgmii_txd_o;
    logic      rgmii_tx_ctl_o;
    logic      rgmii_tx_clk_o;
    logic      gmii_rx_clk_o;
    octet_t    gmii_rxd_o;
    logic      gmii_rx_dv_o;
    logic      gmii_rx_er_o;
    stat_cnt_t frame_cnt_o;
    stat_cnt_t byte_cnt_o;
    stat_cnt_t err_cnt_o;
    stat_cnt_t bad_frame_cnt_o;

    integer    seed;
    octet_t    tx_bytes[$];          // all frame payloads back to back
    logic      tx_errs[$];           // tx_er per payload byte
    int        frame_len[NUM_FRAMES];
    exp_byte_t exp_q[$];             // scoreboard, oldest byte first
    octet_t    exp_data  = '0;
    logic      exp_er    = 1'b0;
    logic      exp_valid = 1'b0;
    int        n_bytes;
    int        n_errs;
    int        n_bad;
    int        tx_cycles;
    longint    timeout_ns;
    int        err_cnt;
    int        pass_tests;
    int        fail_tests;

    // 90 degree forwarded clock, so the looped rx samples mid eye
    rgmii_port #(
        .in_phase_tx_clk (1'b0)
    ) uut (
        .gmii_tx_clk_i   (gmii_tx_clk_i),
        .gmii_tx_clk90_i (gmii_tx_clk90_i),
        .rgmii_rx_clk_i  (rgmii_tx_clk_o),  // loopback
        .rst_i           (rst_i),
        .gmii_txd_i      (gmii_txd_i),
        .gmii_tx_en_i    (gmii_tx_en_i),
        .gmii_tx_er_i    (gmii_tx_er_i),
        .rgmii_txd_o     (rgmii_txd_o),
        .rgmii_tx_ctl_o  (rgmii_tx_ctl_o),
        .rgmii_tx_clk_o  (rgmii_tx_clk_o),
        .rgmii_rxd_i     (rgmii_txd_o),     // loopback
        .rgmii_rx_ctl_i  (rgmii_tx_ctl_o),  // loopback
        .gmii_rx_clk_o   (gmii_rx_clk_o),
        .gmii_rxd_o      (gmii_rxd_o),
        .gmii_rx_dv_o    (gmii_rx_dv_o),
        .gmii_rx_er_o    (gmii_rx_er_o),
        .frame_cnt_o     (frame_cnt_o),
        .byte_cnt_o      (byte_cnt_o),
        .err_cnt_o       (err_cnt_o),
        .bad_frame_cnt_o (bad_frame_cnt_o)
    );

    // clk90 trails the tx clock by a quarter period
    initial
    begin
        gmii_tx_clk_i   = 1'b0;
        gmii_tx_clk90_i = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 4) gmii_tx_clk_i = ~gmii_tx_clk_i;
            #(CLK_PERIOD / 4) gmii_tx_clk90_i = ~gmii_tx_clk90_i;
        end
    end

    // pull the next expected byte whenever the dut shows dv
    initial
    begin
        exp_byte_t head;
        forever
        begin
            @(posedge gmii_rx_clk_o);
            #1; // rx outputs settled after the edge
            exp_valid = 1'b0;
            if (!rst_i && gmii_rx_dv_o)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("extra byte %h on gmii_rxd_o, nothing left to receive", gmii_rxd_o);
                    err_cnt++;
                end
                else
                begin
                    head      = exp_q.pop_front();
                    exp_data  = head.data;
                    exp_er    = head.er;
                    exp_valid = 1'b1;
                end
            end
        end
    end

    // checked mid cycle, rx outputs are stable there
    rxd_match: assert property (@(negedge gmii_rx_clk_o) disable iff (rst_i)
        (gmii_rx_dv_o && exp_valid) |-> (gmii_rxd_o == exp_data))
    else
    begin
        $display("CHECK FAILED gmii_rxd_o got %h expected %h", gmii_rxd_o, exp_data);
        err_cnt++;
    end

    rx_er_match: assert property (@(negedge gmii_rx_clk_o) disable iff (rst_i)
        (gmii_rx_dv_o && exp_valid) |-> (gmii_rx_er_o == exp_er))
    else
    begin
        $display("CHECK FAILED gmii_rx_er_o got %h expected %h", gmii_rx_er_o, exp_er);
        err_cnt++;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // lengths, payloads and error positions, plus the expected totals
    task automatic build_frames();
        int   f;
        int   b;
        int   len;
        int   err_pos;
        int   rnd;
        logic er;
        n_bytes   = 0;
        n_errs    = 0;
        n_bad     = 0;
        tx_cycles = 0;
        for (f = 0; f < NUM_FRAMES; f++)
        begin
            len     = 4 + int'($unsigned($random(seed)) % 13);
            err_pos = int'($unsigned($random(seed)) % len);
            frame_len[f] = len;
            for (b = 0; b < len; b++)
            begin
                rnd = $random(seed);
                // odd frames get one forced error and maybe more
                er = (f % 2 == 1) && (b == err_pos || (rnd & 7) == 0);
                tx_bytes.push_back(octet_t'($random(seed)));
                tx_errs.push_back(er);
                if (er)
                    n_errs++;
            end
            if (f % 2 == 1)
                n_bad++;
            n_bytes   += len;
            tx_cycles += len + GAP_CYCLES;
        end
    endtask

    task automatic drive_cycle(input octet_t d, input logic en, input logic er);
        exp_byte_t item;
        @(posedge gmii_tx_clk_i);
        #2;
        gmii_txd_i   = d;
        gmii_tx_en_i = en;
        gmii_tx_er_i = er;
        if (en)
        begin
            item.er   = er;
            item.data = d;
            exp_q.push_back(item);
        end
    endtask

    task automatic apply_reset();
        // forwarded clock stops in reset, the rx side only sees reset on entry
        repeat (2) @(posedge gmii_tx_clk_i);
        #2;
        rst_i = 1'b1;
        repeat (3) @(posedge gmii_tx_clk_i);
        #2;
        rst_i = 1'b0;
    endtask

    task automatic close_test(input string name, input int errs_before);
        if (err_cnt == errs_before)
        begin
            pass_tests++;
            $display("test %s: ok", name);
        end
        else
        begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial
    begin
        int mark;
        int idx;
        int f;
        int b;
        rst_i        = 1'b0;
        gmii_txd_i   = '0;
        gmii_tx_en_i = 1'b0;
        gmii_tx_er_i = 1'b0;
        err_cnt      = 0;
        pass_tests   = 0;
        fail_tests   = 0;
        seed         = 32'h2db3;
        build_frames();
        timeout_ns = longint'(tx_cycles + SETUP_CYCLES) * CLK_PERIOD * 2;
        apply_reset();

        mark = err_cnt;
        repeat (2) @(negedge gmii_rx_clk_o);
        check_value("gmii_rx_dv_o", 32'(gmii_rx_dv_o), 32'h0);
        check_value("gmii_rx_er_o", 32'(gmii_rx_er_o), 32'h0);
        check_value("frame_cnt_o", 32'(frame_cnt_o), 32'h0);
        check_value("byte_cnt_o", 32'(byte_cnt_o), 32'h0);
        check_value("err_cnt_o", 32'(err_cnt_o), 32'h0);
        check_value("bad_frame_cnt_o", 32'(bad_frame_cnt_o), 32'h0);
        close_test("reset state", mark);

        mark = err_cnt;
        idx  = 0;
        for (f = 0; f < NUM_FRAMES; f++)
        begin
            for (b = 0; b < frame_len[f]; b++)
            begin
                drive_cycle(tx_bytes[idx], 1'b1, tx_errs[idx]);
                idx++;
            end
            for (b = 0; b < GAP_CYCLES; b++)
            begin
                if (f % 2 == 1 && b < 2)
                    drive_cycle(8'h0f, 1'b0, 1'b1); // carrier extension
                else
                    drive_cycle(8'h00, 1'b0, 1'b0);
            end
        end
        while (exp_q.size() != 0)
            @(posedge gmii_tx_clk_i);
        repeat (4) @(negedge gmii_rx_clk_o); // counters trail dv by one clock
        close_test("loopback data and rx_er", mark);

        mark = err_cnt;
        check_value("frame_cnt_o", 32'(frame_cnt_o), NUM_FRAMES);
        check_value("byte_cnt_o", 32'(byte_cnt_o), n_bytes);
        check_value("err_cnt_o", 32'(err_cnt_o), n_errs);
        close_test("statistics counters", mark);

        mark = err_cnt;
        check_value("bad_frame_cnt_o", 32'(bad_frame_cnt_o), n_bad);
        close_test("bad frames", mark);

        $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // limit from the frame schedule, doubled
    initial
    begin
        wait (timeout_ns != 0);
        #(timeout_ns);
        $display("timeout: loopback still busy after %0d ns", timeout_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
